// File: design/text_pkg.sv
package text_pkg;

        ////////////////////
        // Scan position and sync levels
        ////////////////////

        // One word per pixel clock from the timing generator
        typedef struct packed {
                logic [10:0] hcount;
                logic [10:0] vcount;
                logic        hsync;
                logic        vsync;
                logic        hblnk;
                logic        vblnk;
        } vga_timing_t;

        // What leaves the chip each pixel
        typedef struct packed {
                logic        hsync;
                logic        vsync;
                logic [11:0] rgb;
        } vga_out_t;

        ////////////////////
        // Character map and font
        ////////////////////

        // ASCII subset, 7 bits
        typedef logic [6:0] char_code_t;

        // Row in the upper nibble, column in the lower nibble
        typedef logic [7:0] char_xy_t;

        // Glyph size in pixels and lines
        localparam int CHAR_W = 8;
        localparam int CHAR_H = 16;

        ////////////////////
        // Colours, 4 bits per channel
        ////////////////////

        localparam logic [11:0] TEXT_RGB = 12'hff0;
        localparam logic [11:0] BG_RGB   = 12'h114;

endpackage

// File: design/vga_timing.sv
`timescale 1ns/1ns

module vga_timing #(
        parameter int H_TOTAL      = 1056,
        parameter int H_ACTIVE     = 800,
        parameter int H_SYNC_START = 840,
        parameter int H_SYNC_LEN   = 128,
        parameter int V_TOTAL      = 628,
        parameter int V_ACTIVE     = 600,
        parameter int V_SYNC_START = 601,
        parameter int V_SYNC_LEN   = 4
) (
        input  logic                  pclk,
        input  logic                  rst_n,
        output text_pkg::vga_timing_t tim
);

        logic [10:0] hcount_nxt;
        logic [10:0] vcount_nxt;
        logic        hsync_nxt;
        logic        vsync_nxt;
        logic        hblnk_nxt;
        logic        vblnk_nxt;

        ////////////////////
        // Next counter values
        ////////////////////

        always_comb begin
                if (tim.hcount == 11'(H_TOTAL - 1)) begin
                        hcount_nxt = '0;
                        // Line wraps with the last pixel of the frame
                        if (tim.vcount == 11'(V_TOTAL - 1)) begin
                                vcount_nxt = '0;
                        end else begin
                                vcount_nxt = tim.vcount + 11'd1;
                        end
                end else begin
                        hcount_nxt = tim.hcount + 11'd1;
                        vcount_nxt = tim.vcount;
                end
        end

        ////////////////////
        // Sync and blanking, decoded from the next counts
        ////////////////////

        // Positive syncs
        always_comb begin
                hsync_nxt = (hcount_nxt >= 11'(H_SYNC_START)) &&
                            (hcount_nxt < 11'(H_SYNC_START + H_SYNC_LEN));
                vsync_nxt = (vcount_nxt >= 11'(V_SYNC_START)) &&
                            (vcount_nxt < 11'(V_SYNC_START + V_SYNC_LEN));
                hblnk_nxt = hcount_nxt >= 11'(H_ACTIVE);
                vblnk_nxt = vcount_nxt >= 11'(V_ACTIVE);
        end

        // Counts and levels land in the same register, so they stay in step
        always_ff @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        tim <= '0;
                end else begin
                        tim.hcount <= hcount_nxt;
                        tim.vcount <= vcount_nxt;
                        tim.hsync  <= hsync_nxt;
                        tim.vsync  <= vsync_nxt;
                        tim.hblnk  <= hblnk_nxt;
                        tim.vblnk  <= vblnk_nxt;
                end
        end

endmodule

// File: design/multi_char_rom_16x16.sv
`timescale 1ns/1ns

module multi_char_rom_16x16 (
        input  text_pkg::char_xy_t   multi_char_xy,
        output text_pkg::char_code_t multi_char_code
);

        // Fixed screen, MULTI in row 2 from column 6
        always_comb begin
                case (multi_char_xy)
                        8'h26: begin
                                multi_char_code = 7'h4d;   // M
                        end
                        8'h27: begin
                                multi_char_code = 7'h55;   // U
                        end
                        8'h28: begin
                                multi_char_code = 7'h4c;   // L
                        end
                        8'h29: begin
                                multi_char_code = 7'h54;   // T
                        end
                        8'h2a: begin
                                multi_char_code = 7'h49;   // I
                        end
                        // Every other cell is blank
                        default: begin
                                multi_char_code = 7'h20;
                        end
                endcase
        end

endmodule

// File: design/font_rom.sv
`timescale 1ns/1ns

module font_rom (
        input  logic        pclk,
        input  logic [10:0] addr,
        output logic [7:0]  char_line
);

        text_pkg::char_code_t code;
        logic [3:0]           line;
        logic [7:0]           row;

        // Code in the upper bits, glyph line in the lower four
        assign code = addr[10:4];
        assign line = addr[3:0];

        ////////////////////
        // Glyph table, bit 7 is the leftmost pixel
        ////////////////////

        always_comb begin
                row = 8'h00;
                case (code)
                        7'h4d: begin
                                case (line) inside
                                        4'd2: row = 8'b11000110;
                                        4'd3: row = 8'b11101110;
                                        4'd4: row = 8'b11111110;
                                        4'd5: row = 8'b11010110;
                                        [4'd6:4'd11]: row = 8'b11000110;
                                        default: row = 8'h00;
                                endcase
                        end
                        7'h55: begin
                                case (line) inside
                                        [4'd2:4'd10]: row = 8'b11000110;
                                        4'd11: row = 8'b01111100;
                                        default: row = 8'h00;
                                endcase
                        end
                        7'h4c: begin
                                case (line) inside
                                        [4'd2:4'd10]: row = 8'b11000000;
                                        4'd11: row = 8'b11111110;
                                        default: row = 8'h00;
                                endcase
                        end
                        7'h54: begin
                                case (line) inside
                                        4'd2: row = 8'b11111110;
                                        [4'd3:4'd11]: row = 8'b00111000;
                                        default: row = 8'h00;
                                endcase
                        end
                        7'h49: begin
                                case (line) inside
                                        4'd2, 4'd11: row = 8'b01111100;
                                        [4'd3:4'd10]: row = 8'b00111000;
                                        default: row = 8'h00;
                                endcase
                        end
                        // Space and anything not in the table draw nothing
                        default: begin
                                row = 8'h00;
                        end
                endcase
        end

        // One cycle of ROM latency
        always_ff @(posedge pclk) begin
                char_line <= row;
        end

endmodule

// File: design/pipe_delay.sv
`timescale 1ns/1ns

module pipe_delay #(
        parameter type payload_t = logic,
        parameter int  DEPTH     = 1
) (
        input  logic     pclk,
        input  logic     rst_n,
        input  payload_t din,
        output payload_t dout
);

        payload_t stage [DEPTH];

        ////////////////////
        // Shift register
        ////////////////////

        always_ff @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < DEPTH; i++) begin
                                stage[i] <= '0;
                        end
                end else begin
                        stage[0] <= din;
                        // Older entries move one slot along
                        for (int i = 1; i < DEPTH; i++) begin
                                stage[i] <= stage[i-1];
                        end
                end
        end

        assign dout = stage[DEPTH-1];

endmodule

// File: design/char_draw.sv
`timescale 1ns/1ns

module char_draw #(
        parameter int TEXT_X = 300,
        parameter int TEXT_Y = 200
) (
        input  logic                  pclk,
        input  logic                  rst_n,
        input  text_pkg::vga_timing_t tim_in,
        output text_pkg::vga_out_t    vga
);

        // 16 x 16 cells
        localparam int TEXT_W = 16 * text_pkg::CHAR_W;
        localparam int TEXT_H = 16 * text_pkg::CHAR_H;

        logic                  in_rect;
        logic [10:0]           rel_x;
        logic [10:0]           rel_y;
        text_pkg::char_xy_t    char_xy;
        text_pkg::char_code_t  map_code;
        text_pkg::char_code_t  font_code;
        logic [10:0]           font_addr;
        logic [7:0]            char_line;
        logic [2:0]            col;
        logic [2:0]            col_d;
        text_pkg::vga_timing_t tim_d;
        logic                  pix_on;

        ////////////////////
        // Stage 0, addresses
        ////////////////////

        assign rel_x = tim_in.hcount - 11'(TEXT_X);
        assign rel_y = tim_in.vcount - 11'(TEXT_Y);

        assign in_rect = (tim_in.hcount >= 11'(TEXT_X)) &&
                         (tim_in.hcount < 11'(TEXT_X + TEXT_W)) &&
                         (tim_in.vcount >= 11'(TEXT_Y)) &&
                         (tim_in.vcount < 11'(TEXT_Y + TEXT_H));

        // Row of cells above the column of cells
        assign char_xy = {rel_y[7:4], rel_x[6:3]};
        assign col     = rel_x[2:0];

        multi_char_rom_16x16 u_char_map (
                .multi_char_xy   (char_xy),
                .multi_char_code (map_code)
        );

        // Code 0 has no glyph, so outside the box the row comes back empty
        assign font_code = in_rect ? map_code : '0;
        assign font_addr = {font_code, rel_y[3:0]};

        font_rom u_font (
                .pclk      (pclk),
                .addr      (font_addr),
                .char_line (char_line)
        );

        ////////////////////
        // Stage 1, align with the glyph row
        ////////////////////

        pipe_delay #(
                .payload_t (text_pkg::vga_timing_t),
                .DEPTH     (1)
        ) u_tim_dly (
                .pclk  (pclk),
                .rst_n (rst_n),
                .din   (tim_in),
                .dout  (tim_d)
        );

        pipe_delay #(
                .payload_t (logic [2:0]),
                .DEPTH     (1)
        ) u_col_dly (
                .pclk  (pclk),
                .rst_n (rst_n),
                .din   (col),
                .dout  (col_d)
        );

        // Leftmost pixel sits in bit 7
        assign pix_on = char_line[3'd7 - col_d];

        // Output register
        always_ff @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        vga <= '0;
                end else begin
                        vga.hsync <= tim_d.hsync;
                        vga.vsync <= tim_d.vsync;
                        if (tim_d.hblnk || tim_d.vblnk) begin
                                vga.rgb <= 12'h000;
                        end else if (pix_on) begin
                                vga.rgb <= text_pkg::TEXT_RGB;
                        end else begin
                                vga.rgb <= text_pkg::BG_RGB;
                        end
                end
        end

endmodule

// File: design/text_display_top.sv
`timescale 1ns/1ns

module text_display_top #(
        parameter int H_TOTAL      = 1056,
        parameter int H_ACTIVE     = 800,
        parameter int H_SYNC_START = 840,
        parameter int H_SYNC_LEN   = 128,
        parameter int V_TOTAL      = 628,
        parameter int V_ACTIVE     = 600,
        parameter int V_SYNC_START = 601,
        parameter int V_SYNC_LEN   = 4,
        parameter int TEXT_X       = 300,
        parameter int TEXT_Y       = 200
) (
        input  logic               pclk,
        input  logic               rst_n,
        output text_pkg::vga_out_t vga
);

        text_pkg::vga_timing_t tim;

        ////////////////////
        // Frame scan
        ////////////////////

        vga_timing #(
                .H_TOTAL      (H_TOTAL),
                .H_ACTIVE     (H_ACTIVE),
                .H_SYNC_START (H_SYNC_START),
                .H_SYNC_LEN   (H_SYNC_LEN),
                .V_TOTAL      (V_TOTAL),
                .V_ACTIVE     (V_ACTIVE),
                .V_SYNC_START (V_SYNC_START),
                .V_SYNC_LEN   (V_SYNC_LEN)
        ) u_vga_timing (
                .pclk  (pclk),
                .rst_n (rst_n),
                .tim   (tim)
        );

        ////////////////////
        // Text overlay, two cycles behind the scan
        ////////////////////

        char_draw #(
                .TEXT_X (TEXT_X),
                .TEXT_Y (TEXT_Y)
        ) u_char_draw (
                .pclk   (pclk),
                .rst_n  (rst_n),
                .tim_in (tim),
                .vga    (vga)
        );

endmodule

// File: tests/text_display_properties.sv
`timescale 1ns/1ns

module text_display_properties #(
        parameter int H_TOTAL    = 1056,
        parameter int H_SYNC_LEN = 128,
        parameter int V_TOTAL    = 628,
        parameter int V_SYNC_LEN = 4
) (
        input logic               pclk,
        input logic               rst_n,
        input text_pkg::vga_out_t vga
);

        localparam int VS_CYCLES    = V_SYNC_LEN * H_TOTAL;
        localparam int FRAME_CYCLES = V_TOTAL * H_TOTAL;

        // Count of failed properties, watched from the testbench
        int   fail_count;
        int   rst_low;
        int   hs_high;
        int   hs_gap;
        logic hs_prev;
        logic hs_armed;
        int   vs_high;
        int   vs_gap;
        logic vs_prev;
        logic vs_armed;

        ////////////////////
        // Run lengths of the sync pulses
        ////////////////////

        // Cycles spent in reset so far
        always_ff @(posedge pclk) begin
                rst_low <= rst_n ? 0 : rst_low + 1;
        end

        always_ff @(posedge pclk or negedge rst_n) begin
                if (!rst_n) begin
                        hs_prev  <= 1'b0;
                        hs_high  <= 0;
                        hs_gap   <= 0;
                        hs_armed <= 1'b0;
                        vs_prev  <= 1'b0;
                        vs_high  <= 0;
                        vs_gap   <= 0;
                        vs_armed <= 1'b0;
                end else begin
                        hs_prev  <= vga.hsync;
                        hs_high  <= vga.hsync ? hs_high + 1 : 0;
                        hs_gap   <= (vga.hsync && !hs_prev) ? 1 : hs_gap + 1;
                        hs_armed <= hs_armed || (vga.hsync && !hs_prev);
                        vs_prev  <= vga.vsync;
                        vs_high  <= vga.vsync ? vs_high + 1 : 0;
                        vs_gap   <= (vga.vsync && !vs_prev) ? 1 : vs_gap + 1;
                        vs_armed <= vs_armed || (vga.vsync && !vs_prev);
                end
        end

        ////////////////////
        // Properties
        ////////////////////

        a_reset_quiet: assert property (@(posedge pclk) !rst_n && rst_low > 0 |-> vga == '0)
                else begin
                        $error("outputs not at zero while in reset");
                        fail_count++;
                end

        a_reset_release: assert property (@(posedge pclk) $rose(rst_n) |-> vga == '0)
                else begin
                        $error("outputs not at zero in the first cycle after reset");
                        fail_count++;
                end

        a_hsync_width: assert property (@(posedge pclk) disable iff (!rst_n)
                $fell(vga.hsync) |-> hs_high == H_SYNC_LEN)
                else begin
                        $error("hsync pulse is %0d cycles wide", $sampled(hs_high));
                        fail_count++;
                end

        a_hsync_period: assert property (@(posedge pclk) disable iff (!rst_n)
                $rose(vga.hsync) && hs_armed |-> hs_gap == H_TOTAL)
                else begin
                        $error("hsync rose after %0d cycles", $sampled(hs_gap));
                        fail_count++;
                end

        a_vsync_width: assert property (@(posedge pclk) disable iff (!rst_n)
                $fell(vga.vsync) |-> vs_high == VS_CYCLES)
                else begin
                        $error("vsync pulse is %0d cycles wide", $sampled(vs_high));
                        fail_count++;
                end

        a_vsync_period: assert property (@(posedge pclk) disable iff (!rst_n)
                $rose(vga.vsync) && vs_armed |-> vs_gap == FRAME_CYCLES)
                else begin
                        $error("vsync rose after %0d cycles", $sampled(vs_gap));
                        fail_count++;
                end

endmodule

bind text_display_top text_display_properties #(
        .H_TOTAL    (H_TOTAL),
        .H_SYNC_LEN (H_SYNC_LEN),
        .V_TOTAL    (V_TOTAL),
        .V_SYNC_LEN (V_SYNC_LEN)
) u_props (
        .pclk  (pclk),
        .rst_n (rst_n),
        .vga   (vga)
);

// File: tests/text_display_tb.sv
`timescale 1ns/1ns

module text_display_tb;

        localparam int H_TOTAL      = 1056;
        localparam int H_ACTIVE     = 800;
        localparam int H_SYNC_START = 840;
        localparam int H_SYNC_LEN   = 128;
        localparam int V_TOTAL      = 628;
        localparam int V_ACTIVE     = 600;
        localparam int V_SYNC_START = 601;
        localparam int V_SYNC_LEN   = 4;
        localparam int TEXT_X       = 300;
        localparam int TEXT_Y       = 200;
        localparam int TEXT_W       = 16 * text_pkg::CHAR_W;
        localparam int TEXT_H       = 16 * text_pkg::CHAR_H;

        localparam int     CLK_PERIOD      = 100;
        localparam int     RESET_CYCLES    = 16;
        localparam int     FRAMES_TO_RUN   = 2;
        localparam longint WATCHDOG_CYCLES = RESET_CYCLES + 3 * H_TOTAL * V_TOTAL;

        logic               pclk;
        logic               rst_n;
        text_pkg::vga_out_t vga;

        // Scan position rebuilt from the syncs
        logic        hs_prev;
        logic        vs_prev;
        logic        h_lock;
        logic        v_lock;
        int          h_pos;
        int          v_pos;

        // One pixel behind, so position and colour are sampled together
        logic        px_valid;
        int          px_h;
        int          px_v;
        logic [11:0] px_rgb;
        logic [4:0]  lit_cells;
        logic [4:0]  lit_last;
        logic        frame_end;
        int          frames_done;

        text_display_top #(
                .H_TOTAL      (H_TOTAL),
                .H_ACTIVE     (H_ACTIVE),
                .H_SYNC_START (H_SYNC_START),
                .H_SYNC_LEN   (H_SYNC_LEN),
                .V_TOTAL      (V_TOTAL),
                .V_ACTIVE     (V_ACTIVE),
                .V_SYNC_START (V_SYNC_START),
                .V_SYNC_LEN   (V_SYNC_LEN),
                .TEXT_X       (TEXT_X),
                .TEXT_Y       (TEXT_Y)
        ) u_dut (
                .pclk  (pclk),
                .rst_n (rst_n),
                .vga   (vga)
        );

        ////////////////////
        // Failure handling
        ////////////////////

        task automatic abort_run();
                $display("Regression failed");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic report_mismatch(string test_name, logic [15:0] expected,
                                       logic [15:0] actual);
                $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
                abort_run();
        endtask

        task automatic report_problem(string what);
                $display("[ERROR] %s", what);
                abort_run();
        endtask

        ////////////////////
        // Screen geometry
        ////////////////////

        function automatic logic in_text_box(int h, int v);
                return (h >= TEXT_X) && (h < TEXT_X + TEXT_W) &&
                       (v >= TEXT_Y) && (v < TEXT_Y + TEXT_H);
        endfunction

        function automatic int cell_col(int h);
                return (h - TEXT_X) / text_pkg::CHAR_W;
        endfunction

        // MULTI sits in cell row 2, columns 6 to 10
        function automatic logic in_multi_cell(int h, int v);
                return in_text_box(h, v) && ((v - TEXT_Y) / text_pkg::CHAR_H == 2) &&
                       (cell_col(h) >= 6) && (cell_col(h) <= 10);
        endfunction

        ////////////////////
        // Clock, reset, watchdog
        ////////////////////

        initial begin
                pclk = 1'b0;
        end

        always #(CLK_PERIOD / 2) pclk = ~pclk;

        initial begin
                #(WATCHDOG_CYCLES * CLK_PERIOD);
                report_problem("timeout, the scan did not complete two frames");
        end

        ////////////////////
        // Frame-tracking model
        ////////////////////

        always @(posedge pclk) begin : track_scan
                logic hs_rise;
                logic vs_rise;
                logic lock_h;
                logic lock_v;
                int   h_now;
                int   v_now;

                hs_rise = vga.hsync && !hs_prev;
                vs_rise = vga.vsync && !vs_prev;
                lock_h  = h_lock || hs_rise;
                lock_v  = v_lock || (vs_rise && lock_h);
                h_now   = (h_pos == H_TOTAL - 1) ? 0 : h_pos + 1;
                v_now   = v_pos;
                if (hs_rise) begin
                        h_now = H_SYNC_START;
                end
                // Line advances as the pixel count wraps
                if (vs_rise) begin
                        v_now = V_SYNC_START;
                end else if (h_now == 0) begin
                        v_now = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
                end

                if (!rst_n) begin
                        hs_prev     <= 1'b0;
                        vs_prev     <= 1'b0;
                        h_lock      <= 1'b0;
                        v_lock      <= 1'b0;
                        h_pos       <= 0;
                        v_pos       <= 0;
                        px_valid    <= 1'b0;
                        lit_cells   <= '0;
                        lit_last    <= '0;
                        frame_end   <= 1'b0;
                        frames_done <= 0;
                end else begin
                        hs_prev  <= vga.hsync;
                        vs_prev  <= vga.vsync;
                        h_lock   <= lock_h;
                        v_lock   <= lock_v;
                        h_pos    <= h_now;
                        v_pos    <= v_now;
                        px_valid <= lock_h && lock_v;
                        px_h     <= h_now;
                        px_v     <= v_now;
                        px_rgb   <= vga.rgb;
                        if (vs_rise && v_lock) begin
                                frame_end   <= 1'b1;
                                lit_last    <= lit_cells;
                                lit_cells   <= '0;
                                frames_done <= frames_done + 1;
                        end else begin
                                frame_end <= 1'b0;
                                if (lock_v && in_multi_cell(h_now, v_now) &&
                                    vga.rgb == text_pkg::TEXT_RGB) begin
                                        lit_cells[cell_col(h_now) - 6] <= 1'b1;
                                end
                        end
                end
        end

        ////////////////////
        // Checks
        ////////////////////

        a_blank_black: assert property (@(posedge pclk)
                px_valid && (px_h >= H_ACTIVE || px_v >= V_ACTIVE) |-> px_rgb == 12'h000)
                else report_mismatch("blank_black", 16'h000, $sampled(px_rgb));

        a_visible_bg: assert property (@(posedge pclk)
                px_valid && px_h < H_ACTIVE && px_v < V_ACTIVE && !in_text_box(px_h, px_v)
                |-> px_rgb == text_pkg::BG_RGB)
                else report_mismatch("visible_bg", text_pkg::BG_RGB, $sampled(px_rgb));

        a_space_cells: assert property (@(posedge pclk)
                px_valid && in_text_box(px_h, px_v) && !in_multi_cell(px_h, px_v)
                |-> px_rgb == text_pkg::BG_RGB)
                else report_mismatch("space_cells", text_pkg::BG_RGB, $sampled(px_rgb));

        a_multi_colours: assert property (@(posedge pclk)
                px_valid && in_multi_cell(px_h, px_v)
                |-> px_rgb == text_pkg::TEXT_RGB || px_rgb == text_pkg::BG_RGB)
                else report_mismatch("multi_colours", text_pkg::TEXT_RGB, $sampled(px_rgb));

        // Every MULTI cell lit once per frame
        a_multi_lit: assert property (@(posedge pclk) frame_end |-> lit_last == 5'h1f)
                else report_mismatch("multi_lit", 16'h1f, $sampled(lit_last));

        a_props_clean: assert property (@(posedge pclk) u_dut.u_props.fail_count == 0)
                else report_problem("a sync or reset property on the DUT outputs failed");

        ////////////////////
        // Main sequence
        ////////////////////

        initial begin
                rst_n = 1'b0;
                repeat (RESET_CYCLES) @(posedge pclk);
                rst_n <= 1'b1;
                wait (frames_done == FRAMES_TO_RUN);
                // Let the last frame check run
                @(posedge pclk);
                @(posedge pclk);
                if (u_dut.u_props.fail_count != 0) begin
                        report_problem("sync or reset properties recorded a failure");
                end else begin
                        $display("Regression passed");
                        $finish;
                end
        end

endmodule

// File: filelist.f
design/text_pkg.sv
design/vga_timing.sv
design/multi_char_rom_16x16.sv
design/font_rom.sv
design/pipe_delay.sv
design/char_draw.sv
design/text_display_top.sv
tests/text_display_properties.sv
tests/text_display_tb.sv

// File: Bender.yml
package:
  name: text_display

sources:
  - design/text_pkg.sv
  - design/vga_timing.sv
  - design/multi_char_rom_16x16.sv
  - design/font_rom.sv
  - design/pipe_delay.sv
  - design/char_draw.sv
  - design/text_display_top.sv
  - target: test
    files:
      - tests/text_display_properties.sv
      - tests/text_display_tb.sv
